// ==== build.f ====
design/profiler_reason_pkg.sv
design/profiler_bus_pkg.sv
design/stall_reason_pipe.sv
design/read_dma_monitor.sv
design/stall_counter_bank.sv
design/counter_axil_reader.sv
design/commit_profiler.sv
verification/commit_profiler_tb.sv

// ==== design/commit_profiler.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_profiler
  #(parameter int counter_width_p = 32
   )
  (input  logic                                       clk_i
  ,input  logic                                       reset_i

  ,input  logic                                       instr_queue_ready_i
  ,input  logic                                       instr_queue_valid_i
  ,input  profiler_reason_pkg::icache_state_e         icache_state_i
  ,input  logic                                       icache_hit_i

  ,input  logic                                       is_valid_i
  ,input  logic                                       is_ack_i
  ,input  logic                                       is_sb_full_i
  ,input  logic                                       is_unresolved_branch_i
  ,input  logic                                       is_ro_stall_i

  ,input  logic                                       cmt_valid_i
  ,input  logic                                       cmt_ack_i
  ,input  logic                                       exception_i

  ,input  logic                                       en_i

  ,input  logic                                       m_arvalid_i
  ,input  logic                                       m_arready_i
  ,input  logic [profiler_bus_pkg::mem_id_w_c-1:0]    m_arid_i
  ,input  logic                                       m_rlast_i

  ,input  logic [profiler_bus_pkg::axil_addr_w_c-1:0] s_araddr_i
  ,input  logic                                       s_arvalid_i
  ,output logic                                       s_arready_o
  ,output logic [profiler_bus_pkg::axil_data_w_c-1:0] s_rdata_o
  ,output logic [1:0]                                 s_rresp_o
  ,output logic                                       s_rvalid_o
  ,input  logic                                       s_rready_i
  );

  import profiler_reason_pkg::*;

  reason_vec_t                                   reason_vec;
  logic                                          icache_refill;
  logic [counter_width_p-1:0]                    rdma_cnt;
  logic [counter_width_p-1:0]                    rdma_wait;
  logic [num_reasons_c-1:0][counter_width_p-1:0] counts;

  stall_reason_pipe stall_reason_pipe_inst
    (.clk_i                  (clk_i)
    ,.reset_i                (reset_i)
    ,.instr_queue_ready_i    (instr_queue_ready_i)
    ,.instr_queue_valid_i    (instr_queue_valid_i)
    ,.icache_state_i         (icache_state_i)
    ,.icache_hit_i           (icache_hit_i)
    ,.is_valid_i             (is_valid_i)
    ,.is_ack_i               (is_ack_i)
    ,.is_sb_full_i           (is_sb_full_i)
    ,.is_unresolved_branch_i (is_unresolved_branch_i)
    ,.is_ro_stall_i          (is_ro_stall_i)
    ,.cmt_valid_i            (cmt_valid_i)
    ,.cmt_ack_i              (cmt_ack_i)
    ,.exception_i            (exception_i)
    ,.reason_vec_o           (reason_vec)
    );

  read_dma_monitor #(.counter_width_p(counter_width_p)) read_dma_monitor_inst
    (.clk_i           (clk_i)
    ,.reset_i         (reset_i)
    ,.en_i            (en_i)
    ,.m_arvalid_i     (m_arvalid_i)
    ,.m_arready_i     (m_arready_i)
    ,.m_arid_i        (m_arid_i)
    ,.m_rlast_i       (m_rlast_i)
    ,.icache_refill_o (icache_refill)
    ,.rdma_cnt_o      (rdma_cnt)
    ,.rdma_wait_o     (rdma_wait)
    );

  stall_counter_bank #(.counter_width_p(counter_width_p)) stall_counter_bank_inst
    (.clk_i           (clk_i)
    ,.reset_i         (reset_i)
    ,.en_i            (en_i)
    ,.cmt_ack_i       (cmt_ack_i)
    ,.reason_vec_i    (reason_vec)
    ,.icache_refill_i (icache_refill)
    ,.counts_o        (counts)
    );

  counter_axil_reader #(.counter_width_p(counter_width_p)) counter_axil_reader_inst
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.counts_i    (counts)
    ,.rdma_cnt_i  (rdma_cnt)
    ,.rdma_wait_i (rdma_wait)
    ,.s_araddr_i  (s_araddr_i)
    ,.s_arvalid_i (s_arvalid_i)
    ,.s_arready_o (s_arready_o)
    ,.s_rdata_o   (s_rdata_o)
    ,.s_rresp_o   (s_rresp_o)
    ,.s_rvalid_o  (s_rvalid_o)
    ,.s_rready_i  (s_rready_i)
    );

endmodule

`default_nettype wire

// ==== design/counter_axil_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module counter_axil_reader
  #(parameter int counter_width_p = 32
   )
  (input  logic                                     clk_i
  ,input  logic                                     reset_i

  ,input  logic [profiler_reason_pkg::num_reasons_c-1:0][counter_width_p-1:0] counts_i
  ,input  logic [counter_width_p-1:0]               rdma_cnt_i
  ,input  logic [counter_width_p-1:0]               rdma_wait_i

  ,input  logic [profiler_bus_pkg::axil_addr_w_c-1:0] s_araddr_i
  ,input  logic                                     s_arvalid_i
  ,output logic                                     s_arready_o
  ,output logic [profiler_bus_pkg::axil_data_w_c-1:0] s_rdata_o
  ,output logic [1:0]                               s_rresp_o
  ,output logic                                     s_rvalid_o
  ,input  logic                                     s_rready_i
  );

  import profiler_reason_pkg::*;
  import profiler_bus_pkg::*;

  logic [axil_addr_w_c-3:0] word_idx;
  logic [axil_data_w_c-1:0] dec_data;
  logic [1:0]               dec_resp;
  logic                     ar_fire;

  assign word_idx = s_araddr_i[axil_addr_w_c-1:2];

  // Only one read in flight
  assign s_arready_o = ~s_rvalid_o;
  assign ar_fire     = s_arvalid_i & s_arready_o;

  always_comb begin
    dec_data = '0;
    dec_resp = resp_okay_c;
    if (s_araddr_i[1:0] != 2'b00) begin
      dec_resp = resp_slverr_c;
    end else if (s_araddr_i == rdma_cnt_addr_c) begin
      dec_data = axil_data_w_c'(rdma_cnt_i);
    end else if (s_araddr_i == rdma_wait_addr_c) begin
      dec_data = axil_data_w_c'(rdma_wait_i);
    end else if (word_idx < num_reasons_c) begin
      dec_data = axil_data_w_c'(counts_i[word_idx]);
    end else begin
      dec_resp = resp_slverr_c;
    end
  end

  // Data and response sampled at AR, held through back-pressure
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      s_rdata_o <= dec_data;
      s_rresp_o <= dec_resp;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      s_rvalid_o <= 1'b0;
    else if (ar_fire)
      s_rvalid_o <= 1'b1;
    else if (s_rready_i)
      s_rvalid_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== design/profiler_bus_pkg.sv ====
`default_nettype none

package profiler_bus_pkg;

  localparam int axil_addr_w_c = 8;
  localparam int axil_data_w_c = 32;

  localparam logic [1:0] resp_okay_c   = 2'b00;
  localparam logic [1:0] resp_slverr_c = 2'b10;

  // Reason counter i sits at 4*i, DMA counters above them
  localparam logic [axil_addr_w_c-1:0] rdma_cnt_addr_c  = 8'h28;
  localparam logic [axil_addr_w_c-1:0] rdma_wait_addr_c = 8'h2C;

  localparam int mem_id_w_c = 5;

  localparam logic [mem_id_w_c-1:0] icache_master_id_c = 5'd0;

endpackage

`default_nettype wire

// ==== design/profiler_reason_pkg.sv ====
`default_nettype none

package profiler_reason_pkg;

  localparam int num_reasons_c = 10;

  // Lower index wins when several reasons are set
  typedef enum logic [$clog2(num_reasons_c)-1:0] {
    unknown   = 4'd0,
    cmt_haz   = 4'd1,
    exception = 4'd2,
    raw_haz   = 4'd3,
    br_haz    = 4'd4,
    sb_full   = 4'd5,
    ic_dma    = 4'd6,
    ic_miss   = 4'd7,
    ic_flush  = 4'd8,
    iq_full   = 4'd9
  } reason_idx_e;

  typedef logic [num_reasons_c-1:0] reason_vec_t;

  typedef enum logic [2:0] {
    IC_FLUSH = 3'd0,
    IC_IDLE  = 3'd1,
    IC_READ  = 3'd2,
    IC_MISS  = 3'd3
  } icache_state_e;

endpackage

`default_nettype wire

// ==== design/read_dma_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module read_dma_monitor
  #(parameter int counter_width_p = 32
   )
  (input  logic                                  clk_i
  ,input  logic                                  reset_i
  ,input  logic                                  en_i

  ,input  logic                                  m_arvalid_i
  ,input  logic                                  m_arready_i
  ,input  logic [profiler_bus_pkg::mem_id_w_c-1:0] m_arid_i
  ,input  logic                                  m_rlast_i

  ,output logic                                  icache_refill_o
  ,output logic [counter_width_p-1:0]            rdma_cnt_o
  ,output logic [counter_width_p-1:0]            rdma_wait_o
  );

  import profiler_bus_pkg::*;

  logic                  pending_r;
  logic                  rd_pending;
  logic [mem_id_w_c-1:0] id_r;
  logic [mem_id_w_c-1:0] rd_id;

  // New request shows up in the same cycle, last beat ends it
  assign rd_pending = m_arvalid_i ? 1'b1 : (m_rlast_i ? 1'b0 : pending_r);
  assign rd_id      = m_arvalid_i ? m_arid_i : id_r;

  assign icache_refill_o = rd_pending & (rd_id == icache_master_id_c);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r   <= 1'b0;
      id_r        <= '0;
      rdma_cnt_o  <= '0;
      rdma_wait_o <= '0;
    end else begin
      pending_r <= rd_pending;
      id_r      <= rd_id;
      if (en_i & m_arvalid_i & m_arready_i)
        rdma_cnt_o <= rdma_cnt_o + 1'b1;
      if (en_i & rd_pending)
        rdma_wait_o <= rdma_wait_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/stall_counter_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module stall_counter_bank
  #(parameter int counter_width_p = 32
   )
  (input  logic                             clk_i
  ,input  logic                             reset_i
  ,input  logic                             en_i
  ,input  logic                             cmt_ack_i
  ,input  profiler_reason_pkg::reason_vec_t reason_vec_i
  ,input  logic                             icache_refill_i

  ,output logic [profiler_reason_pkg::num_reasons_c-1:0][counter_width_p-1:0] counts_o
  );

  import profiler_reason_pkg::*;

  reason_vec_t refined;
  reason_idx_e sel;

  always_comb begin
    refined = reason_vec_i;
    // Miss while our refill is on the bus counts as DMA wait
    if (reason_vec_i[ic_miss] & icache_refill_i) begin
      refined[ic_miss] = 1'b0;
      refined[ic_dma]  = 1'b1;
    end
  end

  // Lowest set index, unknown when nothing is set
  always_comb begin
    sel = unknown;
    for (int i = num_reasons_c - 1; i >= 0; i--) begin
      if (refined[i])
        sel = reason_idx_e'(i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      counts_o <= '0;
    end else if (en_i & ~cmt_ack_i) begin
      counts_o[sel] <= counts_o[sel] + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/stall_reason_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module stall_reason_pipe
  (input  logic                               clk_i
  ,input  logic                               reset_i

  ,input  logic                               instr_queue_ready_i
  ,input  logic                               instr_queue_valid_i
  ,input  profiler_reason_pkg::icache_state_e icache_state_i
  ,input  logic                               icache_hit_i

  ,input  logic                               is_valid_i
  ,input  logic                               is_ack_i
  ,input  logic                               is_sb_full_i
  ,input  logic                               is_unresolved_branch_i
  ,input  logic                               is_ro_stall_i

  ,input  logic                               cmt_valid_i
  ,input  logic                               cmt_ack_i
  ,input  logic                               exception_i

  ,output profiler_reason_pkg::reason_vec_t   reason_vec_o
  );

  import profiler_reason_pkg::*;

  reason_vec_t fetch_d, fetch_r;
  reason_vec_t queue_d, queue_r;
  reason_vec_t issue_d, issue_r;
  logic        is_stall;

  assign is_stall = is_valid_i & ~is_ack_i;

  always_comb begin
    // Blame the I$ or a full queue at fetch
    fetch_d = '0;
    fetch_d[iq_full]   = ~instr_queue_ready_i;
    fetch_d[ic_flush]  = (icache_state_i == IC_FLUSH);
    fetch_d[ic_miss]   = (icache_state_i == IC_MISS)
                         | ((icache_state_i == IC_READ) & ~icache_hit_i);
    fetch_d[exception] = exception_i;

    // A valid queue output hides whatever happened upstream
    queue_d = '0;
    if (!instr_queue_valid_i) begin
      queue_d = fetch_r;
      queue_d[exception] = queue_d[exception] | exception_i;
    end

    issue_d = queue_r;
    issue_d[exception] = issue_d[exception] | exception_i;
    if (is_stall) begin
      issue_d[sb_full] = issue_d[sb_full] | is_sb_full_i;
      issue_d[br_haz]  = issue_d[br_haz] | is_unresolved_branch_i;
      issue_d[raw_haz] = issue_d[raw_haz] | is_ro_stall_i;
    end
  end

  always_comb begin
    reason_vec_o = issue_r;
    reason_vec_o[exception] = issue_r[exception] | exception_i;
    reason_vec_o[cmt_haz]   = issue_r[cmt_haz] | (cmt_valid_i & ~cmt_ack_i);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_r <= '0;
      queue_r <= '0;
      issue_r <= '0;
    end else begin
      fetch_r <= fetch_d;
      queue_r <= queue_d;
      issue_r <= issue_d;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module commit_profiler_tb -f build.f

# The simulator status is not trusted, the log decides
./obj_dir/Vcommit_profiler_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation finished cleanly"

// ==== verification/commit_profiler_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_profiler_tb;

  import profiler_reason_pkg::*;
  import profiler_bus_pkg::*;

  logic                     clk_i;
  logic                     reset_i;
  logic                     instr_queue_ready_i;
  logic                     instr_queue_valid_i;
  icache_state_e            icache_state_i;
  logic                     icache_hit_i;
  logic                     is_valid_i;
  logic                     is_ack_i;
  logic                     is_sb_full_i;
  logic                     is_unresolved_branch_i;
  logic                     is_ro_stall_i;
  logic                     cmt_valid_i;
  logic                     cmt_ack_i;
  logic                     exception_i;
  logic                     en_i;
  logic                     m_arvalid_i;
  logic                     m_arready_i;
  logic [mem_id_w_c-1:0]    m_arid_i;
  logic                     m_rlast_i;
  logic [axil_addr_w_c-1:0] s_araddr_i;
  logic                     s_arvalid_i;
  logic                     s_arready_o;
  logic [axil_data_w_c-1:0] s_rdata_o;
  logic [1:0]               s_rresp_o;
  logic                     s_rvalid_o;
  logic                     s_rready_i;

  // Reference model state
  reason_vec_t           fetch_m;
  reason_vec_t           queue_m;
  reason_vec_t           issue_m;
  logic                  pending_m;
  logic [mem_id_w_c-1:0] id_m;
  logic [31:0]           cnt_m [num_reasons_c];
  logic [31:0]           rdma_cnt_m;
  logic [31:0]           rdma_wait_m;
  logic [31:0]           rng;

  commit_profiler commit_profiler_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  always @(posedge clk_i) begin : model_step
    reason_vec_t           f_d;
    reason_vec_t           q_d;
    reason_vec_t           i_d;
    reason_vec_t           vec;
    logic                  pend;
    logic [mem_id_w_c-1:0] cur_id;
    int                    pick;
    logic                  found;
    if (reset_i) begin
      fetch_m     <= '0;
      queue_m     <= '0;
      issue_m     <= '0;
      pending_m   <= 1'b0;
      id_m        <= '0;
      rdma_cnt_m  <= '0;
      rdma_wait_m <= '0;
      for (int i = 0; i < num_reasons_c; i++)
        cnt_m[i] <= '0;
    end else begin
      f_d = '0;
      f_d[iq_full]   = !instr_queue_ready_i;
      f_d[ic_flush]  = (icache_state_i == IC_FLUSH);
      f_d[ic_miss]   = (icache_state_i == IC_MISS) || (icache_state_i == IC_READ && !icache_hit_i);
      f_d[exception] = exception_i;
      q_d = instr_queue_valid_i ? '0 : fetch_m;
      if (!instr_queue_valid_i && exception_i)
        q_d[exception] = 1'b1;
      i_d = queue_m;
      if (exception_i)
        i_d[exception] = 1'b1;
      if (is_valid_i && !is_ack_i) begin
        i_d[sb_full] = i_d[sb_full] || is_sb_full_i;
        i_d[br_haz]  = i_d[br_haz] || is_unresolved_branch_i;
        i_d[raw_haz] = i_d[raw_haz] || is_ro_stall_i;
      end
      vec = issue_m;
      vec[exception] = vec[exception] || exception_i;
      vec[cmt_haz]   = vec[cmt_haz] || (cmt_valid_i && !cmt_ack_i);
      // Pending flag and ID see a new request in its own cycle
      pend   = m_arvalid_i || (!m_rlast_i && pending_m);
      cur_id = m_arvalid_i ? m_arid_i : id_m;
      if (vec[ic_miss] && pend && cur_id == icache_master_id_c) begin
        vec[ic_miss] = 1'b0;
        vec[ic_dma]  = 1'b1;
      end
      pick  = 0;
      found = 1'b0;
      for (int i = 0; i < num_reasons_c; i++) begin
        if (!found && vec[i]) begin
          pick  = i;
          found = 1'b1;
        end
      end
      if (en_i && !cmt_ack_i)
        cnt_m[pick] <= cnt_m[pick] + 32'd1;
      if (en_i && m_arvalid_i && m_arready_i)
        rdma_cnt_m <= rdma_cnt_m + 32'd1;
      if (en_i && pend)
        rdma_wait_m <= rdma_wait_m + 32'd1;
      fetch_m   <= f_d;
      queue_m   <= q_d;
      issue_m   <= i_d;
      pending_m <= pend;
      id_m      <= cur_id;
    end
  end

  task automatic stop_with_failure;
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
      stop_with_failure();
    end
  endtask

  // Frontend and issue idle, commit acknowledging, memory bus silent
  task automatic quiet_inputs;
    instr_queue_ready_i    <= 1'b1;
    instr_queue_valid_i    <= 1'b1;
    icache_state_i         <= IC_IDLE;
    icache_hit_i           <= 1'b1;
    is_valid_i             <= 1'b0;
    is_ack_i               <= 1'b0;
    is_sb_full_i           <= 1'b0;
    is_unresolved_branch_i <= 1'b0;
    is_ro_stall_i          <= 1'b0;
    cmt_valid_i            <= 1'b0;
    cmt_ack_i              <= 1'b1;
    exception_i            <= 1'b0;
    m_arvalid_i            <= 1'b0;
    m_arready_i            <= 1'b0;
    m_arid_i               <= '0;
    m_rlast_i              <= 1'b0;
  endtask

  task automatic random_cycle;
    logic [31:0] r;
    rng = xorshift32(rng);
    r   = rng;
    @(posedge clk_i);
    instr_queue_ready_i    <= r[0] | r[1];
    instr_queue_valid_i    <= r[2] & r[3];
    icache_state_i         <= icache_state_e'(r[5:4]);
    icache_hit_i           <= r[6];
    is_valid_i             <= r[7];
    is_ack_i               <= r[8] & r[9];
    is_sb_full_i           <= r[10];
    is_unresolved_branch_i <= r[11];
    is_ro_stall_i          <= r[12];
    cmt_valid_i            <= r[13];
    cmt_ack_i              <= r[14];
    exception_i            <= (r[18:15] == 4'd0);
    m_arvalid_i            <= (r[21:19] == 3'd0);
    m_arready_i            <= r[22];
    m_arid_i               <= r[23] ? icache_master_id_c : r[28:24];
    m_rlast_i              <= (r[31:29] == 3'd0);
  endtask

  // One AXI4-Lite read with RREADY held low for hold cycles first
  task automatic axil_read(input logic [7:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp, input string name, input int hold);
    int          waited;
    logic [31:0] first;
    logic [1:0]  first_resp;
    @(posedge clk_i);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    s_rready_i  <= (hold == 0);
    waited = 0;
    @(negedge clk_i);
    while (!s_arready_o) begin
      waited++;
      if (waited > 50)
        abort_run("s_arready_o stayed low, read address never accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    // Point away from the sampled register while the response waits
    s_araddr_i  <= addr ^ 8'h01;
    waited = 0;
    @(negedge clk_i);
    while (!s_rvalid_o) begin
      waited++;
      if (waited > 50)
        abort_run("s_rvalid_o never rose after the address handshake");
      @(negedge clk_i);
    end
    check_value({name, "_data"}, exp_data, s_rdata_o);
    check_value({name, "_resp"}, {30'd0, exp_resp}, {30'd0, s_rresp_o});
    first      = s_rdata_o;
    first_resp = s_rresp_o;
    repeat (hold) begin
      @(negedge clk_i);
      check_value({name, "_held"}, first, s_rdata_o);
      check_value({name, "_held_resp"}, {30'd0, first_resp}, {30'd0, s_rresp_o});
      assert (s_rvalid_o) else abort_run("s_rvalid_o dropped while s_rready_i was low");
      assert (!s_arready_o)
        else abort_run("s_arready_o high while a read response was still pending");
    end
    @(posedge clk_i);
    s_rready_i <= 1'b1;
    @(posedge clk_i);
  endtask

  // Freeze counting, then read every register against the model
  task automatic compare_all(input string name);
    @(posedge clk_i);
    en_i <= 1'b0;
    @(negedge clk_i);
    for (int i = 0; i < num_reasons_c; i++)
      axil_read(8'(4 * i), cnt_m[i], resp_okay_c, $sformatf("%s_reason%0d", name, i), i % 3);
    axil_read(rdma_cnt_addr_c, rdma_cnt_m, resp_okay_c, {name, "_rdma_cnt"}, 1);
    axil_read(rdma_wait_addr_c, rdma_wait_m, resp_okay_c, {name, "_rdma_wait"}, 0);
    @(posedge clk_i);
    en_i <= 1'b1;
  endtask

  initial begin
    rng = 32'd51615;
    reset_i     <= 1'b1;
    en_i        <= 1'b1;
    s_araddr_i  <= '0;
    s_arvalid_i <= 1'b0;
    s_rready_i  <= 1'b1;
    quiet_inputs();
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    compare_all("reset");

    // Stall with no cause, then with counting disabled
    @(posedge clk_i);
    cmt_ack_i <= 1'b0;
    repeat (20) @(posedge clk_i);
    compare_all("no_cause");
    @(posedge clk_i);
    en_i <= 1'b0;
    repeat (20) @(posedge clk_i);
    compare_all("disabled");

    // Every mix of issue and commit hazards, each held for its own length
    for (int k = 0; k < 32; k++) begin
      @(posedge clk_i);
      is_valid_i             <= 1'b1;
      is_ack_i               <= 1'b0;
      is_sb_full_i           <= k[0];
      is_unresolved_branch_i <= k[1];
      is_ro_stall_i          <= k[2];
      cmt_valid_i            <= k[3];
      exception_i            <= k[4];
      repeat (k + 1) @(posedge clk_i);
    end
    compare_all("issue");

    // I$ miss, then refills by the I$ master and by another master
    @(posedge clk_i);
    quiet_inputs();
    cmt_ack_i           <= 1'b0;
    instr_queue_valid_i <= 1'b0;
    icache_state_i      <= IC_MISS;
    repeat (6) @(posedge clk_i);
    m_arvalid_i <= 1'b1;
    m_arready_i <= 1'b1;
    m_arid_i    <= icache_master_id_c;
    @(posedge clk_i);
    m_arvalid_i <= 1'b0;
    m_rlast_i   <= 1'b1;
    @(posedge clk_i);
    m_rlast_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    m_arvalid_i <= 1'b1;
    @(posedge clk_i);
    m_arvalid_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    m_rlast_i <= 1'b1;
    @(posedge clk_i);
    m_rlast_i   <= 1'b0;
    m_arvalid_i <= 1'b1;
    m_arid_i    <= 5'd3;
    @(posedge clk_i);
    m_arvalid_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    compare_all("icache");

    for (int blk = 0; blk < 6; blk++) begin
      repeat (400) random_cycle();
      compare_all($sformatf("random%0d", blk));
    end

    axil_read(8'h30, 32'd0, resp_slverr_c, "unmapped_30", 2);
    axil_read(8'hFC, 32'd0, resp_slverr_c, "unmapped_fc", 3);
    axil_read(8'h06, 32'd0, resp_slverr_c, "unaligned_06", 1);
    axil_read(8'h29, 32'd0, resp_slverr_c, "unaligned_29", 0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
